// File: src/exu_pkg.sv
// ------------------------------------------------
// Shared widths, word types and command encodings
// for the execution stage. Imported by every block.
// ------------------------------------------------
package exu_pkg;

    localparam int xlen = 32;                       // Data word width

    typedef logic [xlen-1:0] xlen_t;                // Data word or PC
    typedef logic [4:0]      reg_addr_t;            // Register-file address

    // ------------------------------------------------
    // Command encodings
    // ------------------------------------------------
    typedef enum logic [4:0] {
        ialu_cmd_none,
        ialu_cmd_add,
        ialu_cmd_sub,
        ialu_cmd_and,
        ialu_cmd_or,
        ialu_cmd_xor,
        ialu_cmd_sll,
        ialu_cmd_srl,
        ialu_cmd_sra,
        ialu_cmd_slt,
        ialu_cmd_sltu,
        ialu_cmd_eq,                                // Compares drive cmp only
        ialu_cmd_ne,
        ialu_cmd_lt,
        ialu_cmd_ge,
        ialu_cmd_ltu,
        ialu_cmd_geu
    } ialu_cmd_e;

    typedef enum logic {
        ialu_op_reg_reg,                            // op2 from rs2
        ialu_op_reg_imm                             // op2 from immediate
    } ialu_op_e;

    typedef enum logic {
        sum2_op_pc_imm,                             // Branch and JAL targets
        sum2_op_reg_imm                             // JALR targets
    } sum2_op_e;

    typedef enum logic [2:0] {
        rd_wb_none,
        rd_wb_ialu,
        rd_wb_sum2,
        rd_wb_imm,                                  // LUI
        rd_wb_inc_pc                                // Link address
    } rd_wb_sel_e;

    typedef enum logic [3:0] {
        exc_instr_misalign = 4'd0,
        exc_illegal_instr  = 4'd2,
        exc_ecall_m        = 4'd11
    } exc_code_e;

    localparam xlen_t pc_inc    = 32'd4;            // No compressed instructions
    localparam xlen_t jump_mask = 32'hffff_fffe;    // Clears target bit 0

endpackage

// File: src/exu_cmd_if.sv
// ------------------------------------------------
// Queued command, driven by the control block and
// read by the ALU, PC and write-back blocks.
// ------------------------------------------------
interface exu_cmd_if;
    import exu_pkg::*;

    logic       vd;                                 // Queue entry valid
    ialu_cmd_e  ialu_cmd;
    ialu_op_e   ialu_op;
    sum2_op_e   sum2_op;
    rd_wb_sel_e rd_wb_sel;
    xlen_t      imm;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    reg_addr_t  rd_addr;
    logic       jump_req;
    logic       branch_req;
    logic       exc_req;                            // Exception flagged by decode
    exc_code_e  exc_code;

    modport ctrl (output vd, ialu_cmd, ialu_op, sum2_op, rd_wb_sel, imm, rs1_addr,
                  rs2_addr, rd_addr, jump_req, branch_req, exc_req, exc_code);
    modport dp   (input  vd, ialu_cmd, ialu_op, sum2_op, rd_wb_sel, imm, rs1_addr,
                  rs2_addr, rd_addr, jump_req, branch_req, exc_req, exc_code);
endinterface

// File: src/exu_ctrl.sv
// ------------------------------------------------
// Stage control: one-entry command queue, jump and
// branch resolution, exceptions and redirect request.
// ------------------------------------------------
module exu_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  idu_req,          // Level request from decode
    input  exu_pkg::ialu_cmd_e    idu_ialu_cmd,
    input  exu_pkg::ialu_op_e     idu_ialu_op,
    input  exu_pkg::sum2_op_e     idu_sum2_op,
    input  exu_pkg::rd_wb_sel_e   idu_rd_wb_sel,
    input  exu_pkg::xlen_t        idu_imm,
    input  exu_pkg::reg_addr_t    idu_rs1_addr,
    input  exu_pkg::reg_addr_t    idu_rs2_addr,
    input  exu_pkg::reg_addr_t    idu_rd_addr,
    input  logic                  idu_jump_req,
    input  logic                  idu_branch_req,
    input  logic                  idu_exc_req,
    input  exu_pkg::exc_code_e    idu_exc_code,
    exu_cmd_if.ctrl               cmd,
    input  logic                  cmp,              // Branch condition from ALU
    input  exu_pkg::xlen_t        sum2_res,         // Raw jump target
    input  logic                  init_pc,
    output logic                  jb_taken,
    output logic                  new_pc_req,
    output logic                  exc_req,
    output logic                  instret,
    output logic                  take_exc,
    output exu_pkg::exc_code_e    exc_code
);
    import exu_pkg::*;

    xlen_t jb_target;                               // Target with bit 0 cleared
    logic  jb_misalign;

    // ------------------------------------------------
    // Command queue
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd.vd <= 1'b0;
        end else begin
            cmd.vd <= idu_req & ~new_pc_req;        // Flush on redirect
        end
    end

    always_ff @(posedge clk) begin
        if (idu_req) begin                          // Payload only, no reset
            cmd.ialu_cmd   <= idu_ialu_cmd;
            cmd.ialu_op    <= idu_ialu_op;
            cmd.sum2_op    <= idu_sum2_op;
            cmd.rd_wb_sel  <= idu_rd_wb_sel;
            cmd.imm        <= idu_imm;
            cmd.rs1_addr   <= idu_rs1_addr;
            cmd.rs2_addr   <= idu_rs2_addr;
            cmd.rd_addr    <= idu_rd_addr;
            cmd.jump_req   <= idu_jump_req;
            cmd.branch_req <= idu_branch_req;
            cmd.exc_req    <= idu_exc_req;
            cmd.exc_code   <= idu_exc_code;
        end
    end

    // ------------------------------------------------
    // Resolution and exceptions
    // ------------------------------------------------
    assign jb_taken    = cmd.vd & (cmd.jump_req | (cmd.branch_req & cmp));
    assign jb_target   = sum2_res & jump_mask;
    assign jb_misalign = jb_taken & jb_target[1];   // Not word aligned

    assign exc_req  = cmd.vd & (cmd.exc_req | jb_misalign);
    assign take_exc = exc_req;

    always_comb begin
        if (cmd.exc_req) begin                      // Decode fault wins
            exc_code = cmd.exc_code;
        end else if (jb_misalign) begin
            exc_code = exc_instr_misalign;
        end else begin
            exc_code = exc_ecall_m;                 // Idle value
        end
    end

    assign new_pc_req = init_pc | jb_taken | exc_req;
    assign instret    = cmd.vd;                     // Single-cycle retire

endmodule

// File: src/exu_ialu.sv
// ------------------------------------------------
// Integer ALU with operand selection, address adder
// and branch comparator. Purely combinational.
// ------------------------------------------------
module exu_ialu (
    exu_cmd_if.dp          cmd,
    input  exu_pkg::xlen_t rs1_data,
    input  exu_pkg::xlen_t rs2_data,
    input  exu_pkg::xlen_t curr_pc,
    output exu_pkg::xlen_t ialu_res,
    output exu_pkg::xlen_t sum2_res,
    output logic           cmp
);
    import exu_pkg::*;

    xlen_t      op1;
    xlen_t      op2;
    xlen_t      sum2_op1;
    logic [4:0] shamt;                              // Shift amount
    logic       lt_s;                               // Signed less-than
    logic       lt_u;                               // Unsigned less-than

    // ------------------------------------------------
    // Operand fetch
    // ------------------------------------------------
    assign op1      = rs1_data;
    assign op2      = (cmd.ialu_op == ialu_op_reg_reg) ? rs2_data : cmd.imm;
    assign sum2_op1 = (cmd.sum2_op == sum2_op_reg_imm) ? rs1_data : curr_pc;
    assign sum2_res = sum2_op1 + cmd.imm;           // Jump target or link base

    assign shamt = op2[4:0];
    assign lt_s  = $signed(op1) < $signed(op2);
    assign lt_u  = op1 < op2;

    // ------------------------------------------------
    // Main ALU
    // ------------------------------------------------
    always_comb begin
        ialu_res = '0;
        cmp      = 1'b0;
        case (cmd.ialu_cmd)
            ialu_cmd_add  : ialu_res = op1 + op2;
            ialu_cmd_sub  : ialu_res = op1 - op2;
            ialu_cmd_and  : ialu_res = op1 & op2;
            ialu_cmd_or   : ialu_res = op1 | op2;
            ialu_cmd_xor  : ialu_res = op1 ^ op2;
            ialu_cmd_sll  : ialu_res = op1 << shamt;
            ialu_cmd_srl  : ialu_res = op1 >> shamt;
            ialu_cmd_sra  : ialu_res = xlen_t'($signed(op1) >>> shamt);
            ialu_cmd_slt  : ialu_res = {{(xlen-1){1'b0}}, lt_s};
            ialu_cmd_sltu : ialu_res = {{(xlen-1){1'b0}}, lt_u};
            ialu_cmd_eq   : cmp = (op1 == op2);
            ialu_cmd_ne   : cmp = (op1 != op2);
            ialu_cmd_lt   : cmp = lt_s;
            ialu_cmd_ge   : cmp = ~lt_s;
            ialu_cmd_ltu  : cmp = lt_u;
            ialu_cmd_geu  : cmp = ~lt_u;
            default       : ;                       // None, result stays zero
        endcase
    end

endmodule

// File: src/exu_pc.sv
// ------------------------------------------------
// Program counter, reset-exit sequencer and next-PC
// selection. Vectors come from the top level.
// ------------------------------------------------
module exu_pc #(
    parameter exu_pkg::xlen_t rst_vector  = 32'h200,
    parameter exu_pkg::xlen_t trap_vector = 32'h100
) (
    input  logic           clk,
    input  logic           rst_n,
    exu_cmd_if.dp          cmd,
    input  logic           jb_taken,
    input  logic           new_pc_req,
    input  logic           exc_req,
    input  logic           instret,
    input  exu_pkg::xlen_t sum2_res,
    output logic           init_pc,
    output exu_pkg::xlen_t curr_pc,
    output exu_pkg::xlen_t inc_pc,
    output exu_pkg::xlen_t new_pc
);
    import exu_pkg::*;

    logic [3:0] init_pc_v;                          // Reset-exit shifter

    // ------------------------------------------------
    // Reset exit, one pulse after the third edge
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_pc_v <= '0;
        end else if (!(&init_pc_v)) begin
            init_pc_v <= {init_pc_v[2:0], 1'b1};    // Fill with ones
        end
    end

    assign init_pc = ~init_pc_v[3] & init_pc_v[2];

    assign inc_pc = curr_pc + pc_inc;

    always_comb begin
        if (init_pc) begin
            new_pc = rst_vector;
        end else if (exc_req) begin                 // Trap beats the jump
            new_pc = trap_vector;
        end else if (jb_taken) begin
            new_pc = sum2_res & jump_mask;
        end else begin
            new_pc = cmd.vd ? inc_pc : curr_pc;     // Sequential next PC
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc <= rst_vector;
        end else if (instret | init_pc) begin
            curr_pc <= new_pc_req ? new_pc : inc_pc;
        end
    end

endmodule

// File: src/exu_wb.sv
// ------------------------------------------------
// Register-file write-back and trap value selection
// for the retiring command.
// ------------------------------------------------
module exu_wb (
    exu_cmd_if.dp              cmd,
    input  logic               exc_req,
    input  exu_pkg::xlen_t     ialu_res,
    input  exu_pkg::xlen_t     sum2_res,
    input  exu_pkg::xlen_t     inc_pc,
    output logic               mprf_w_req,
    output exu_pkg::reg_addr_t mprf_rd_addr,
    output exu_pkg::xlen_t     mprf_rd_data,
    output exu_pkg::xlen_t     trap_val,
    input  exu_pkg::exc_code_e exc_code
);
    import exu_pkg::*;

    // No write when the command traps
    assign mprf_w_req   = cmd.vd & (cmd.rd_wb_sel != rd_wb_none) & ~exc_req;
    assign mprf_rd_addr = cmd.rd_addr;

    always_comb begin
        case (cmd.rd_wb_sel)
            rd_wb_sum2   : mprf_rd_data = sum2_res;     // AUIPC
            rd_wb_imm    : mprf_rd_data = cmd.imm;
            rd_wb_inc_pc : mprf_rd_data = inc_pc;       // Link for JAL/JALR
            default      : mprf_rd_data = ialu_res;
        endcase
    end

    always_comb begin
        case (exc_code)
            exc_instr_misalign : trap_val = sum2_res & jump_mask;
            exc_illegal_instr  : trap_val = cmd.imm;    // Faulting instruction word
            default            : trap_val = '0;
        endcase
    end

endmodule

// File: src/exu_top.sv
// ------------------------------------------------
// Execution stage top level. Connects decode and the
// register file through plain ports.
// ------------------------------------------------
module exu_top #(
    parameter exu_pkg::xlen_t rst_vector  = 32'h200,
    parameter exu_pkg::xlen_t trap_vector = 32'h100
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  idu_req,
    input  exu_pkg::ialu_cmd_e    ialu_cmd,
    input  exu_pkg::ialu_op_e     ialu_op,
    input  exu_pkg::sum2_op_e     sum2_op,
    input  exu_pkg::rd_wb_sel_e   rd_wb_sel,
    input  exu_pkg::xlen_t        imm,
    input  exu_pkg::reg_addr_t    rs1_addr,
    input  exu_pkg::reg_addr_t    rs2_addr,
    input  exu_pkg::reg_addr_t    rd_addr,
    input  logic                  jump_req,
    input  logic                  branch_req,
    input  logic                  exc_req,
    input  exu_pkg::exc_code_e    exc_code,
    output exu_pkg::reg_addr_t    mprf_rs1_addr,
    output exu_pkg::reg_addr_t    mprf_rs2_addr,
    input  exu_pkg::xlen_t        mprf_rs1_data,
    input  exu_pkg::xlen_t        mprf_rs2_data,
    output logic                  mprf_w_req,
    output exu_pkg::reg_addr_t    mprf_rd_addr,
    output exu_pkg::xlen_t        mprf_rd_data,
    output logic                  take_exc,
    output exu_pkg::exc_code_e    exc_code_out,
    output exu_pkg::xlen_t        trap_val,
    output exu_pkg::xlen_t        curr_pc,
    output logic                  new_pc_req,
    output exu_pkg::xlen_t        new_pc,
    output logic                  instret,
    output logic                  init_pc
);
    import exu_pkg::*;

    xlen_t ialu_res;
    xlen_t sum2_res;
    xlen_t inc_pc;
    logic  cmp;
    logic  jb_taken;
    logic  exu_exc_req;                             // Stage exception, any source

    exu_cmd_if cmd ();

    assign mprf_rs1_addr = cmd.rs1_addr;            // Read ports follow the queue
    assign mprf_rs2_addr = cmd.rs2_addr;

    exu_ctrl i_ctrl (
        .clk(clk), .rst_n(rst_n), .idu_req(idu_req),
        .idu_ialu_cmd(ialu_cmd), .idu_ialu_op(ialu_op), .idu_sum2_op(sum2_op),
        .idu_rd_wb_sel(rd_wb_sel), .idu_imm(imm), .idu_rs1_addr(rs1_addr),
        .idu_rs2_addr(rs2_addr), .idu_rd_addr(rd_addr), .idu_jump_req(jump_req),
        .idu_branch_req(branch_req), .idu_exc_req(exc_req), .idu_exc_code(exc_code),
        .cmd(cmd.ctrl), .cmp(cmp), .sum2_res(sum2_res), .init_pc(init_pc),
        .jb_taken(jb_taken), .new_pc_req(new_pc_req), .exc_req(exu_exc_req),
        .instret(instret), .take_exc(take_exc), .exc_code(exc_code_out)
    );

    exu_ialu i_ialu (
        .cmd(cmd.dp), .rs1_data(mprf_rs1_data), .rs2_data(mprf_rs2_data),
        .curr_pc(curr_pc), .ialu_res(ialu_res), .sum2_res(sum2_res), .cmp(cmp)
    );

    exu_pc #(.rst_vector(rst_vector), .trap_vector(trap_vector)) i_pc (
        .clk(clk), .rst_n(rst_n), .cmd(cmd.dp), .jb_taken(jb_taken),
        .new_pc_req(new_pc_req), .exc_req(exu_exc_req), .instret(instret),
        .sum2_res(sum2_res), .init_pc(init_pc), .curr_pc(curr_pc),
        .inc_pc(inc_pc), .new_pc(new_pc)
    );

    exu_wb i_wb (
        .cmd(cmd.dp), .exc_req(exu_exc_req), .ialu_res(ialu_res),
        .sum2_res(sum2_res), .inc_pc(inc_pc), .mprf_w_req(mprf_w_req),
        .mprf_rd_addr(mprf_rd_addr), .mprf_rd_data(mprf_rd_data),
        .trap_val(trap_val), .exc_code(exc_code_out)
    );

endmodule

// File: tb/exu_checker.sv
// ------------------------------------------------
// Concurrent assertions on the stage control block.
// Bound into exu_ctrl from the testbench top level.
// ------------------------------------------------
module exu_checker (
    input logic clk,
    input logic rst_n,
    input logic init_pc,
    input logic new_pc_req,
    input logic queue_vd                            // Queue valid, same as instret
);
    timeunit 1ns;
    timeprecision 1ps;

    // Reset-exit redirect is a single pulse
    init_pulse: assert property (@(posedge clk) disable iff (!rst_n) init_pc |=> !init_pc)
        else $error("init_pc stayed high for more than one cycle");

    flush_on_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        new_pc_req |=> !queue_vd)                   // Queue flushed by redirect
        else $error("queue still valid in the cycle after a redirect");

endmodule

// File: tb/exu_tb.sv
// ------------------------------------------------
// Testbench for the execution stage. Random commands
// from an LFSR, a register-file model, a reference
// function and a per-cycle compare process.
// ------------------------------------------------
module exu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import exu_pkg::*;

    localparam xlen_t rst_vec     = 32'h200;
    localparam xlen_t trap_vec    = 32'h100;
    localparam int    n_cmds      = 200;
    localparam int    cycle_limit = 10 + 2 * n_cmds;    // Counted after reset

    typedef struct packed {
        ialu_cmd_e  ialu_cmd;
        ialu_op_e   ialu_op;
        sum2_op_e   sum2_op;
        rd_wb_sel_e rd_wb_sel;
        xlen_t      imm;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        logic       jump;
        logic       branch;
        logic       exc;
        exc_code_e  exc_code;
    } cmd_t;

    typedef struct packed {
        logic      w_req;
        xlen_t     rd_data;
        logic      taken;
        logic      exc;
        exc_code_e code;
        xlen_t     trap_val;
        logic      redirect;
        xlen_t     new_pc;
        xlen_t     next_pc;
    } exp_t;

    logic      clk;
    logic      rst_n;
    logic      idu_req;
    cmd_t      drv;                                 // Command on the decode ports
    reg_addr_t rs1_a;
    reg_addr_t rs2_a;
    xlen_t     rs1_d;
    xlen_t     rs2_d;
    logic      mprf_w_req;
    reg_addr_t mprf_rd_addr;
    xlen_t     mprf_rd_data;
    logic      take_exc;
    exc_code_e exc_code_out;
    xlen_t     trap_val;
    xlen_t     curr_pc;
    logic      new_pc_req;
    xlen_t     new_pc;
    logic      instret;
    logic      init_pc;

    xlen_t rf [32];                                 // Register file seen by the DUT
    xlen_t ref_rf [32];                             // Reference copy
    xlen_t ref_pc = rst_vec;
    xlen_t lfsr   = 32'hf97d;
    cmd_t  q;                                       // Model of the queue entry
    logic  q_vd = 1'b0;
    exp_t  e;
    logic  exp_init;
    logic  redirect;
    int    neg_cnt = 0;
    int    cycles  = 0;
    int    n_alu = 0;
    int    n_taken = 0;
    int    n_not_taken = 0;
    int    n_dec_exc = 0;
    int    n_misalign = 0;
    int    n_flushed = 0;

    exu_top #(.rst_vector(rst_vec), .trap_vector(trap_vec)) dut0 (
        .clk(clk), .rst_n(rst_n), .idu_req(idu_req),
        .ialu_cmd(drv.ialu_cmd), .ialu_op(drv.ialu_op), .sum2_op(drv.sum2_op),
        .rd_wb_sel(drv.rd_wb_sel), .imm(drv.imm), .rs1_addr(drv.rs1),
        .rs2_addr(drv.rs2), .rd_addr(drv.rd), .jump_req(drv.jump),
        .branch_req(drv.branch), .exc_req(drv.exc), .exc_code(drv.exc_code),
        .mprf_rs1_addr(rs1_a), .mprf_rs2_addr(rs2_a),
        .mprf_rs1_data(rs1_d), .mprf_rs2_data(rs2_d),
        .mprf_w_req(mprf_w_req), .mprf_rd_addr(mprf_rd_addr),
        .mprf_rd_data(mprf_rd_data), .take_exc(take_exc),
        .exc_code_out(exc_code_out), .trap_val(trap_val), .curr_pc(curr_pc),
        .new_pc_req(new_pc_req), .new_pc(new_pc), .instret(instret),
        .init_pc(init_pc)
    );

    bind exu_ctrl exu_checker chk0 (
        .clk(clk), .rst_n(rst_n), .init_pc(init_pc),
        .new_pc_req(new_pc_req), .queue_vd(instret)
    );

    // ------------------------------------------------
    // Clock and register-file model
    // ------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    assign rs1_d = (rs1_a == '0) ? '0 : rf[rs1_a];  // x0 reads zero
    assign rs2_d = (rs2_a == '0) ? '0 : rf[rs2_a];

    always @(posedge clk) begin
        if (mprf_w_req && mprf_rd_addr != '0) begin
            rf[mprf_rd_addr] <= mprf_rd_data;
        end
    end

    // ------------------------------------------------
    // Random source, x^32 + x^22 + x^2 + x + 1
    // ------------------------------------------------
    function automatic xlen_t lfsr_next(input xlen_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic xlen_t take_bits(input int n);
        xlen_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);                 // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic xlen_t jump_offset();
        xlen_t raw;
        xlen_t off;
        raw = take_bits(10);
        off = {{20{raw[9]}}, raw[9:0], 2'b00};      // Word aligned
        if (take_bits(3) == '0) begin
            off[1] = 1'b1;                          // Misaligned now and then
        end
        return off;
    endfunction

    function automatic cmd_t draw_cmd();
        cmd_t  c;
        xlen_t kind;
        xlen_t raw;
        c         = '0;
        kind      = take_bits(3);
        c.ialu_op = ialu_op_e'(take_bits(1));
        c.sum2_op = sum2_op_e'(take_bits(1));
        c.rs1     = reg_addr_t'(take_bits(5));
        c.rs2     = reg_addr_t'(take_bits(5));
        c.rd      = reg_addr_t'(take_bits(5));
        raw       = take_bits(12);
        c.imm     = {{20{raw[11]}}, raw[11:0]};     // I-type style immediate
        case (kind)
            4: begin                                // Conditional branch
                c.branch   = 1'b1;
                c.ialu_op  = ialu_op_reg_reg;
                c.sum2_op  = sum2_op_pc_imm;
                c.ialu_cmd = ialu_cmd_e'(5'd11 + 5'(take_bits(3) % 6));
                c.imm      = jump_offset();
            end
            5: begin                                // JAL or JALR
                c.jump      = 1'b1;
                c.rd_wb_sel = rd_wb_inc_pc;
                c.imm       = jump_offset();
            end
            6: begin                                // Fault flagged by decode
                c.exc       = 1'b1;
                c.exc_code  = take_bits(1) ? exc_illegal_instr : exc_ecall_m;
                c.ialu_cmd  = ialu_cmd_add;
                c.rd_wb_sel = rd_wb_ialu;
            end
            7: c.rd_wb_sel = take_bits(1) ? rd_wb_sum2 : rd_wb_imm;
            default: begin
                c.ialu_cmd  = ialu_cmd_e'(5'd1 + 5'(take_bits(4) % 10));
                c.rd_wb_sel = rd_wb_ialu;
            end
        endcase
        return c;
    endfunction

    // ------------------------------------------------
    // Reference model of one retiring command
    // ------------------------------------------------
    function automatic exp_t ref_exec(input cmd_t c, input xlen_t a, input xlen_t b,
                                      input xlen_t pc);
        exp_t               r;
        xlen_t              op2;
        xlen_t              alu;
        xlen_t              sum;
        xlen_t              tgt;
        logic               cond;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        op2  = (c.ialu_op == ialu_op_reg_imm) ? c.imm : b;
        sum  = ((c.sum2_op == sum2_op_reg_imm) ? a : pc) + c.imm;
        tgt  = {sum[31:1], 1'b0};
        sa   = a;
        sb   = op2;
        alu  = '0;
        cond = 1'b0;
        case (c.ialu_cmd)
            ialu_cmd_add  : alu = a + op2;
            ialu_cmd_sub  : alu = a - op2;
            ialu_cmd_and  : alu = a & op2;
            ialu_cmd_or   : alu = a | op2;
            ialu_cmd_xor  : alu = a ^ op2;
            ialu_cmd_sll  : alu = a << op2[4:0];
            ialu_cmd_srl  : alu = a >> op2[4:0];
            ialu_cmd_sra  : alu = sa >>> op2[4:0];
            ialu_cmd_slt  : alu = xlen_t'(sa < sb);
            ialu_cmd_sltu : alu = xlen_t'(a < op2);
            ialu_cmd_eq   : cond = (a == op2);
            ialu_cmd_ne   : cond = (a != op2);
            ialu_cmd_lt   : cond = (sa < sb);
            ialu_cmd_ge   : cond = (sa >= sb);
            ialu_cmd_ltu  : cond = (a < op2);
            ialu_cmd_geu  : cond = (a >= op2);
            default       : ;
        endcase
        r.taken    = c.jump | (c.branch & cond);
        r.exc      = c.exc | (r.taken & tgt[1]);    // Target not word aligned
        r.code     = c.exc ? c.exc_code : exc_instr_misalign;
        r.trap_val = (r.code == exc_illegal_instr) ? c.imm :
                     (r.code == exc_instr_misalign) ? tgt : '0;
        r.w_req    = (c.rd_wb_sel != rd_wb_none) & ~r.exc;
        case (c.rd_wb_sel)
            rd_wb_sum2   : r.rd_data = sum;
            rd_wb_imm    : r.rd_data = c.imm;
            rd_wb_inc_pc : r.rd_data = pc + 32'd4;  // Link address
            default      : r.rd_data = alu;
        endcase
        r.redirect = r.taken | r.exc;
        r.new_pc   = r.exc ? trap_vec : tgt;
        r.next_pc  = r.redirect ? r.new_pc : pc + 32'd4;
        return r;
    endfunction

    // ------------------------------------------------
    // Compare tasks
    // ------------------------------------------------
    task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input string what, input reg_addr_t got,
                              input reg_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_exc(input string what, input exc_code_e got,
                             input exc_code_e exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // ------------------------------------------------
    // Compare process, mid-cycle when outputs are stable
    // ------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            neg_cnt  = neg_cnt + 1;
            exp_init = (neg_cnt == 4);              // After third edge out of reset
            if (q_vd) begin
                e = ref_exec(q, ref_rf[q.rs1], ref_rf[q.rs2], ref_pc);
            end else begin
                e = '0;
            end
            redirect = exp_init | e.redirect;
            check_flag("init_pc", init_pc, exp_init);
            check_flag("instret", instret, q_vd);
            check_word("curr_pc", curr_pc, ref_pc);
            check_flag("new_pc_req", new_pc_req, redirect);
            check_flag("mprf_w_req", mprf_w_req, e.w_req);
            check_flag("take_exc", take_exc, e.exc);
            if (exp_init) begin
                check_word("new_pc", new_pc, rst_vec);
            end else if (e.redirect) begin
                check_word("new_pc", new_pc, e.new_pc);
            end
            if (e.w_req) begin
                check_addr("mprf_rd_addr", mprf_rd_addr, q.rd);
                check_word("mprf_rd_data", mprf_rd_data, e.rd_data);
                if (q.rd != '0) begin
                    ref_rf[q.rd] = e.rd_data;
                end
            end
            if (e.exc) begin
                check_exc("exc_code_out", exc_code_out, e.code);
                check_word("trap_val", trap_val, e.trap_val);
            end
            if (q_vd) begin
                ref_pc      = e.next_pc;
                n_alu       = n_alu + int'(e.w_req && q.rd_wb_sel == rd_wb_ialu);
                n_taken     = n_taken + int'(e.taken & ~e.exc);
                n_not_taken = n_not_taken + int'(q.branch & ~e.taken);
                n_dec_exc   = n_dec_exc + int'(q.exc);
                n_misalign  = n_misalign + int'(e.exc & ~q.exc);
            end
            n_flushed = n_flushed + int'(idu_req & redirect);
            q_vd      = idu_req & ~redirect;        // Entry for the next cycle
            q         = drv;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles = cycles + 1;
            if (cycles > cycle_limit) begin
                $display("Run did not finish within %0d cycles", cycle_limit);
                $display("Test failed");
                $fatal(1);
            end
        end
    end

    // ------------------------------------------------
    // Stimulus
    // ------------------------------------------------
    initial begin
        rst_n   = 1'b0;
        idu_req = 1'b0;
        drv     = '0;
        rf[0]     = '0;
        ref_rf[0] = '0;
        for (int i = 1; i < 32; i++) begin
            rf[i]     = take_bits(32);              // Random per entry
            ref_rf[i] = rf[i];
        end
        repeat (5) @(posedge clk);
        #10 rst_n = 1'b1;
        do begin
            @(posedge clk);
            #10;
        end while (!init_pc);
        idu_req = 1'b1;                             // Lands in the reset redirect
        drv     = draw_cmd();
        for (int i = 0; i < n_cmds; i++) begin
            @(posedge clk);
            #10;
            idu_req = (take_bits(3) != '0);
            drv     = draw_cmd();
        end
        @(posedge clk);
        #10 idu_req = 1'b0;
        repeat (2) @(posedge clk);
        if (n_alu == 0 || n_taken == 0 || n_not_taken == 0 || n_dec_exc == 0 ||
            n_misalign == 0 || n_flushed == 0) begin
            $display("Random commands missed a required case");
            $display("Test failed");
            $fatal(1);
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: list.f
src/exu_pkg.sv
src/exu_cmd_if.sv
src/exu_ctrl.sv
src/exu_ialu.sv
src/exu_pc.sv
src/exu_wb.sv
src/exu_top.sv
tb/exu_checker.sv
tb/exu_tb.sv

// File: Bender.yml
package:
  name: exu

sources:
  - src/exu_pkg.sv
  - src/exu_cmd_if.sv
  - src/exu_ctrl.sv
  - src/exu_ialu.sv
  - src/exu_pc.sv
  - src/exu_wb.sv
  - src/exu_top.sv
  - target: test
    files:
      - tb/exu_checker.sv
      - tb/exu_tb.sv
